// File: build.f
+incdir+source
source/fetch_pkg.sv
source/fetch_pc.sv
source/fetch_queue.sv
source/fetch_top.sv
tb/fetch_chk.sv
tb/fetch_tb.sv

// File: Makefile
TOP := fetch_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f -o sim_fetch
	./obj_dir/sim_fetch | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// File: tb/fetch_tb.sv
// Testbench for the fetch stage with memory model, dispatch model and row table
`timescale 1ns/1ns
`include "fetch_defines.svh"

module fetch_tb import fetch_pkg::*;;

    localparam logic [1:0] MODE_FULL = 2'd0;    // Take all shown
    localparam logic [1:0] MODE_HOLD = 2'd1;    // Take nothing for a while, then all
    localparam logic [1:0] MODE_RAND = 2'd2;    // LFSR take count
    localparam int NUM_ROWS    = 6;
    localparam int ROW_TIMEOUT = 400;           // Cycles per row

    typedef struct packed
    {
        logic [`XLEN-1:0]   start_pc;           // Redirect target except row 0
        logic [7:0]         count;              // Instructions to collect
        logic [1:0]         mode;
        logic [7:0]         hold;               // Stall cycles in hold mode
        logic               redir_en;           // Mid row redirect
        logic [7:0]         redir_at;           // After this many collected
        logic [`XLEN-1:0]   redir_pc;
    } row_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{`RESET_PC,     8'd12, MODE_FULL, 8'd0,  1'b0, 8'd0, 32'h0},
        '{32'h0000_2004, 8'd8,  MODE_FULL, 8'd0,  1'b0, 8'd0, 32'h0},
        '{32'h0000_3000, 8'd10, MODE_HOLD, 8'd24, 1'b0, 8'd0, 32'h0},
        '{32'h0000_4000, 8'd10, MODE_FULL, 8'd0,  1'b1, 8'd4, 32'h0000_5008},
        '{32'h0000_6004, 8'd24, MODE_RAND, 8'd0,  1'b0, 8'd0, 32'h0},
        '{32'h0000_7000, 8'd16, MODE_RAND, 8'd0,  1'b1, 8'd6, 32'h0000_8004}
    };

    logic                               clk_i;
    logic                               rst_i;
    logic                               redirect_i;
    logic [`XLEN-1:0]                   redirect_pc_i;
    logic                               wb_cyc_o;
    logic                               wb_stb_o;
    logic                               wb_we_o;
    logic [`XLEN-1:0]                   wb_adr_o;
    logic                               wb_ack_i;
    fetch_block_u                       wb_dat_i;
    logic [`DP_NUM_WIDTH-1:0]           dp_avail_o;
    logic [`DP_NUM-1:0][`XLEN-1:0]      dp_inst_o;
    logic [`DP_NUM-1:0][`XLEN-1:0]      dp_pc_o;
    logic [`DP_NUM_WIDTH-1:0]           dp_take_i;

    logic [7:0]         lfsr;                   // Random state
    logic               mem_busy;               // Memory model saw this request
    int                 mem_wait;               // Cycles left before ack
    logic [`XLEN-1:0]   exp_pc;                 // Next PC dispatch must show
    int                 n_checks;
    int                 n_errors;
    int                 row_errors;

    fetch_top uut
    (
        .clk_i(clk_i), .rst_i(rst_i), .redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i),
        .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o), .wb_adr_o(wb_adr_o),
        .wb_ack_i(wb_ack_i), .wb_dat_i(wb_dat_i),
        .dp_avail_o(dp_avail_o), .dp_inst_o(dp_inst_o), .dp_pc_o(dp_pc_o),
        .dp_take_i(dp_take_i)
    );

    bind fetch_top fetch_chk u_chk
    (
        .clk_i(clk_i), .rst_i(rst_i), .redirect_i(redirect_i),
        .cyc_i(wb_cyc_o), .stb_i(wb_stb_o), .adr_i(wb_adr_o), .ack_i(wb_ack_i),
        .avail_i(dp_avail_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;            // 40 ns period
    end

    // ====================
    // Models
    // ====================
    // Galois LFSR, x^8+x^6+x^5+x^4+1, one step per bit
    function automatic logic next_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out)
            lfsr = lfsr ^ 8'hB8;
        return out;
    endfunction

    // Instruction word stored at a byte address
    function automatic logic [`XLEN-1:0] mem_word(input logic [`XLEN-1:0] addr);
        return (addr * 32'h9E37_79B9) ^ 32'h1357_9BDF;
    endfunction

    // Wishbone classic slave, 0 to 3 cycles of wait, one cycle ack
    task automatic serve_memory();
        fetch_block_u blk;
        if (wb_ack_i)
        begin
            wb_ack_i = 1'b0;
            mem_busy = 1'b0;
        end
        else if (wb_cyc_o && wb_stb_o)
        begin
            if (!mem_busy)
            begin
                mem_busy = 1'b1;
                compare("wb_we_o", 32'd0, 32'(wb_we_o));    // Fetch only ever reads
                mem_wait = int'({next_bit(), next_bit()});
            end
            if (mem_wait == 0)
            begin
                for (int k = 0; k < `INST_PER_BLOCK; k++)
                    blk.inst[k] = mem_word(wb_adr_o + 32'(4 * k));    // Low word first
                wb_dat_i = blk;
                wb_ack_i = 1'b1;
            end
            else
                mem_wait--;
        end
        else
            mem_busy = 1'b0;                    // Request dropped by redirect
    endtask

    task automatic tick();
        @(negedge clk_i);
        redirect_i = 1'b0;
        serve_memory();
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        if (act !== exp)
        begin
            n_errors++;
            row_errors++;
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // ====================
    // One table row
    // ====================
    task automatic run_row(input int r);
        row_t row;
        int cyc;
        int got;
        int take;
        int avail;
        logic redir_done;
        logic flush_chk;
        row = ROWS[r];
        row_errors = 0;
        cyc = 0;
        got = 0;
        redir_done = 1'b0;
        flush_chk = 1'b0;
        exp_pc = row.start_pc;
        if (r != 0)
        begin
            tick();
            redirect_i = 1'b1;                  // Start PC comes in as a redirect
            redirect_pc_i = row.start_pc;
            dp_take_i = '0;
            flush_chk = 1'b1;
        end
        while (got < int'(row.count) && cyc < ROW_TIMEOUT)
        begin
            tick();
            cyc++;
            if (flush_chk)
            begin
                compare("dp_avail_o", 32'd0, 32'(dp_avail_o));
                flush_chk = 1'b0;
            end
            if (row.redir_en && !redir_done && got >= int'(row.redir_at))
            begin
                redirect_i = 1'b1;
                redirect_pc_i = row.redir_pc;
                dp_take_i = '0;
                exp_pc = row.redir_pc;          // Stream restarts at target
                redir_done = 1'b1;
                flush_chk = 1'b1;
            end
            else
            begin
                avail = int'(dp_avail_o);
                case (row.mode)
                    MODE_HOLD: take = (cyc <= int'(row.hold)) ? 0 : avail;
                    MODE_RAND:
                    begin
                        take = int'(next_bit()) + int'(next_bit());
                        if (take > avail)
                            take = avail;
                    end
                    default:   take = avail;
                endcase
                // Queue full and bus idle near the end of the stall
                if (row.mode == MODE_HOLD && cyc <= int'(row.hold) && cyc > int'(row.hold) - 8)
                begin
                    compare("dp_avail_o", 32'd2, 32'(dp_avail_o));
                    compare("wb_stb_o", 32'd0, 32'(wb_stb_o));
                end
                if (take > int'(row.count) - got)
                    take = int'(row.count) - got;
                for (int n = 0; n < take; n++)
                begin
                    compare($sformatf("dp_pc_o[%0d]", n), exp_pc, dp_pc_o[n]);
                    compare($sformatf("dp_inst_o[%0d]", n), mem_word(exp_pc), dp_inst_o[n]);
                    exp_pc = exp_pc + 32'd4;
                    got++;
                end
                dp_take_i = 2'(take);
            end
        end
        if (got < int'(row.count))
        begin
            n_errors++;
            row_errors++;
            $display("Row %0d timed out after %0d cycles with %0d of %0d instructions dispatched",
                     r, cyc, got, row.count);
        end
        $display("Row %0d done: start %h, %0d instructions, %0d errors",
                 r, row.start_pc, got, row_errors);
    endtask

    // ====================
    // Main sequence
    // ====================
    initial
    begin
        rst_i = 1'b1;
        redirect_i = 1'b0;
        redirect_pc_i = '0;
        wb_ack_i = 1'b0;
        wb_dat_i = '0;
        dp_take_i = '0;
        lfsr = 8'd35;
        mem_busy = 1'b0;
        mem_wait = 0;
        n_checks = 0;
        n_errors = 0;
        row_errors = 0;
        repeat (16) @(negedge clk_i);
        rst_i = 1'b0;
        // Reset state before the first request
        compare("wb_cyc_o", 32'd0, 32'(wb_cyc_o));
        compare("wb_stb_o", 32'd0, 32'(wb_stb_o));
        compare("dp_avail_o", 32'd0, 32'(dp_avail_o));
        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule : fetch_tb

// File: tb/fetch_chk.sv
// Bus and dispatch protocol assertions bound onto the fetch stage top
`timescale 1ns/1ns
`include "fetch_defines.svh"

module fetch_chk
(
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        redirect_i,
    input  logic                        cyc_i,          // Wishbone cycle from DUT
    input  logic                        stb_i,
    input  logic [`XLEN-1:0]            adr_i,
    input  logic                        ack_i,          // Memory ack
    input  logic [`DP_NUM_WIDTH-1:0]    avail_i         // Dispatch count shown
);

    localparam int BLK_LSB = $clog2(`BLOCK_BYTES);

    // ====================
    // Wishbone
    // ====================
    a_stb_cyc: assert property (@(posedge clk_i) disable iff (rst_i) stb_i |-> cyc_i)
        else $error("Strobe raised outside a bus cycle");

    a_adr_align: assert property (@(posedge clk_i) disable iff (rst_i)
        stb_i |-> (adr_i[BLK_LSB-1:0] == '0))
        else $error("Fetch address not block aligned");

    // Request held with a stable address until ack, a redirect may abandon it
    a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        (stb_i && !ack_i && !redirect_i) |=> (stb_i && $stable(adr_i)))
        else $error("Strobe or address changed before ack");

    // ====================
    // Dispatch
    // ====================
    a_flush: assert property (@(posedge clk_i) disable iff (rst_i)
        redirect_i |=> (avail_i == '0))
        else $error("Queue not empty after redirect");

endmodule : fetch_chk

// File: source/fetch_top.sv
// Fetch stage top joining the PC and bus unit with the fetch queue
`timescale 1ns/1ns
`include "fetch_defines.svh"

module fetch_top import fetch_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                redirect_i,     // Branch mispredict
    input  logic [`XLEN-1:0]                    redirect_pc_i,
    // Wishbone classic master
    output logic                                wb_cyc_o,
    output logic                                wb_stb_o,
    output logic                                wb_we_o,
    output logic [`XLEN-1:0]                    wb_adr_o,
    input  logic                                wb_ack_i,
    input  fetch_block_u                        wb_dat_i,
    // Dispatch side
    output logic [`DP_NUM_WIDTH-1:0]            dp_avail_o,
    output logic [`DP_NUM-1:0][`XLEN-1:0]       dp_inst_o,
    output logic [`DP_NUM-1:0][`XLEN-1:0]       dp_pc_o,
    input  logic [`DP_NUM_WIDTH-1:0]            dp_take_i
);

    // ====================
    // Internal wiring
    // ====================
    logic [`FIQ_IDX_WIDTH:0]    free_num;       // Queue back to PC unit
    logic [`FIQ_IDX_WIDTH:0]    ins_num;        // PC unit into queue
    logic [`XLEN-1:0]           ins_pc;
    fetch_block_u               ins_data;

    fetch_pc u_pc
    (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .redirect_i     (redirect_i),
        .redirect_pc_i  (redirect_pc_i),
        .wb_ack_i       (wb_ack_i),
        .wb_dat_i       (wb_dat_i),
        .free_num_i     (free_num),
        .wb_cyc_o       (wb_cyc_o),
        .wb_stb_o       (wb_stb_o),
        .wb_we_o        (wb_we_o),
        .wb_adr_o       (wb_adr_o),
        .ins_num_o      (ins_num),
        .ins_pc_o       (ins_pc),
        .ins_data_o     (ins_data)
    );

    fetch_queue u_queue
    (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .redirect_i     (redirect_i),           // Same cycle flush as PC reload
        .ins_num_i      (ins_num),
        .ins_pc_i       (ins_pc),
        .ins_data_i     (ins_data),
        .dp_take_i      (dp_take_i),
        .free_num_o     (free_num),
        .dp_avail_o     (dp_avail_o),
        .dp_inst_o      (dp_inst_o),
        .dp_pc_o        (dp_pc_o)
    );

endmodule : fetch_top

// File: source/fetch_queue.sv
// Circular fetch queue taking block inserts and presenting the oldest entries to dispatch
`timescale 1ns/1ns
`include "fetch_defines.svh"

module fetch_queue import fetch_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                redirect_i,     // Flush all entries
    input  logic [`FIQ_IDX_WIDTH:0]             ins_num_i,      // Already capped to free space
    input  logic [`XLEN-1:0]                    ins_pc_i,       // PC of first inserted word
    input  fetch_block_u                        ins_data_i,
    input  logic [`DP_NUM_WIDTH-1:0]            dp_take_i,      // Taken this cycle
    output logic [`FIQ_IDX_WIDTH:0]             free_num_o,
    output logic [`DP_NUM_WIDTH-1:0]            dp_avail_o,
    output logic [`DP_NUM-1:0][`XLEN-1:0]       dp_inst_o,      // Entry 0 is the oldest
    output logic [`DP_NUM-1:0][`XLEN-1:0]       dp_pc_o
);

    localparam int IDX_W    = `FIQ_IDX_WIDTH;
    localparam int CNT_W    = IDX_W + 1;                // Pointer and count width
    localparam int DPW      = `DP_NUM_WIDTH;
    localparam int WORD_LSB = $clog2(`XLEN / 8);
    localparam int SEL_W    = $clog2(`INST_PER_BLOCK);  // Word select inside a block

    // ====================
    // Storage and pointers
    // ====================
    logic [`FIQ_NUM-1:0][`XLEN-1:0]     inst_mem;
    logic [`FIQ_NUM-1:0][`XLEN-1:0]     pc_mem;
    logic [CNT_W-1:0]                   head_q;         // Oldest entry, MSB is wrap
    logic [CNT_W-1:0]                   tail_q;         // Next free entry, MSB is wrap

    logic [CNT_W-1:0]                   used_num;       // Occupancy
    logic [`FIQ_NUM-1:0]                ins_win;        // Entries written at this edge
    logic [`FIQ_NUM-1:0][IDX_W-1:0]     ins_off;        // Slot distance past the tail
    logic [SEL_W-1:0]                   word_off;       // First block word to insert

    // ====================
    // Occupancy
    // ====================
    assign used_num   = tail_q - head_q;                // Wrap bit tells full from empty
    assign free_num_o = CNT_W'(`FIQ_NUM) - used_num;

    always_comb
    begin
        // Cap at dispatch width
        if (used_num > CNT_W'(`DP_NUM))
            dp_avail_o = DPW'(`DP_NUM);
        else
            dp_avail_o = DPW'(used_num);
    end

    // Dispatch view, oldest first
    always_comb
    begin
        logic [IDX_W-1:0] rd_idx;
        for (int n = 0; n < `DP_NUM; n++)
        begin
            rd_idx       = head_q[IDX_W-1:0] + IDX_W'(n);  // Wraps by width
            dp_inst_o[n] = inst_mem[rd_idx];
            dp_pc_o[n]   = pc_mem[rd_idx];
        end
    end

    // ====================
    // Insert window
    // ====================
    assign word_off = ins_pc_i[WORD_LSB +: SEL_W];

    // Each entry checks if it lies within ins_num slots after the tail
    // Modulo distance covers the wrap past the last entry
    always_comb
    begin
        for (int e = 0; e < `FIQ_NUM; e++)
        begin
            ins_off[e] = IDX_W'(e) - tail_q[IDX_W-1:0];
            ins_win[e] = !redirect_i && (CNT_W'(ins_off[e]) < ins_num_i);
        end
    end

    // Payload write, block words steered into the window
    always_ff @(posedge clk_i)
    begin
        for (int e = 0; e < `FIQ_NUM; e++)
        begin
            if (ins_win[e])
            begin
                inst_mem[e] <= ins_data_i.inst[SEL_W'(word_off + ins_off[e])];
                pc_mem[e]   <= ins_pc_i + {ins_off[e], WORD_LSB'(0)};   // 4 bytes per slot
            end
        end
    end

    // ====================
    // Pointer update
    // ====================
    always_ff @(posedge clk_i)
    begin
        if (rst_i || redirect_i)
        begin
            head_q <= '0;                               // Empty queue
            tail_q <= '0;
        end
        else
        begin
            // Pop and insert may share an edge
            head_q <= head_q + CNT_W'(dp_take_i);
            tail_q <= tail_q + ins_num_i;
        end
    end

endmodule : fetch_queue

// File: source/fetch_pc.sv
// PC unit that fetches instruction blocks over a Wishbone classic read port
`timescale 1ns/1ns
`include "fetch_defines.svh"

module fetch_pc import fetch_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        redirect_i,         // Mispredict, reload PC
    input  logic [`XLEN-1:0]            redirect_pc_i,      // New fetch target
    input  logic                        wb_ack_i,
    input  fetch_block_u                wb_dat_i,
    input  logic [`FIQ_IDX_WIDTH:0]     free_num_i,         // Free queue entries
    output logic                        wb_cyc_o,
    output logic                        wb_stb_o,
    output logic                        wb_we_o,
    output logic [`XLEN-1:0]            wb_adr_o,
    output logic [`FIQ_IDX_WIDTH:0]     ins_num_o,          // Entries to write, ack cycle only
    output logic [`XLEN-1:0]            ins_pc_o,           // PC of first written entry
    output fetch_block_u                ins_data_o
);

    localparam int CNT_W    = `FIQ_IDX_WIDTH + 1;       // Counts up to queue depth
    localparam int WORD_LSB = $clog2(`XLEN / 8);        // Byte bits inside a word
    localparam int BLK_LSB  = $clog2(`BLOCK_BYTES);     // Byte bits inside a block

    // ====================
    // State
    // ====================
    logic [`XLEN-1:0]               pc_q;               // Next instruction to fetch
    logic                           busy_q;             // Bus cycle open, one at a time

    logic                           ack_ok;             // Ack that is honored
    logic [BLK_LSB-WORD_LSB-1:0]    word_off;           // Word position of PC in block
    logic [CNT_W-1:0]               rem_num;            // Instructions from PC to block end

    // ====================
    // Insert cap
    // ====================
    assign ack_ok   = busy_q && wb_ack_i && !redirect_i;    // Redirect cycle drops the ack
    assign word_off = pc_q[BLK_LSB-1:WORD_LSB];
    assign rem_num  = CNT_W'(`INST_PER_BLOCK) - CNT_W'(word_off);  // 2 at offset 0, 1 at 4

    always_comb
    begin
        ins_num_o = '0;                                 // Nothing outside the ack cycle
        if (ack_ok)
        begin
            // Clip to free space, the rest is refetched later
            ins_num_o = (rem_num < free_num_i) ? rem_num : free_num_i;
        end
    end

    // Block and its start PC go straight to the queue
    assign ins_pc_o   = pc_q;
    assign ins_data_o = wb_dat_i;

    // ====================
    // PC and bus state
    // ====================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            pc_q   <= `RESET_PC;
            busy_q <= 1'b0;
        end
        else if (redirect_i)
        begin
            pc_q   <= redirect_pc_i;                    // Open cycle is abandoned
            busy_q <= 1'b0;
        end
        else if (ack_ok)
        begin
            // Advance by what was written; zero keeps PC and refetches
            pc_q   <= pc_q + {ins_num_o, WORD_LSB'(0)};
            busy_q <= 1'b0;                             // One idle cycle, free count settles
        end
        else if (!busy_q)
        begin
            busy_q <= (free_num_i != '0);               // Start only with room in queue
        end
    end

    // ====================
    // Wishbone master
    // ====================
    // Address only moves on ack or redirect, so it holds while strobed
    assign wb_cyc_o = busy_q;
    assign wb_stb_o = busy_q;
    assign wb_we_o  = 1'b0;                             // Read only port
    assign wb_adr_o = {pc_q[`XLEN-1:BLK_LSB], BLK_LSB'(0)};    // Block aligned

endmodule : fetch_pc

// File: source/fetch_pkg.sv
// Fetch types, one memory block seen as raw bus data or as instructions
`include "fetch_defines.svh"

package fetch_pkg;

    // ====================
    // Memory block view
    // ====================

    // Same double word, decoded two ways
    // Bus side reads it raw, queue side picks instructions out of it
    typedef union packed
    {
        logic [`BLOCK_BYTES*8-1:0]                  dat;    // Raw Wishbone data
        logic [`INST_PER_BLOCK-1:0][`XLEN-1:0]      inst;   // Element 0 is the low word
    } fetch_block_u;

    // Lower address sits in the low word, so inst[0] comes first in program order
    // A block at offset 4 only yields inst[1]

endpackage : fetch_pkg

// File: source/fetch_defines.svh
// Fetch stage widths, sizes and reset vector shared by RTL and testbench
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// ====================
// Datapath
// ====================
`define XLEN            32              // Instruction and PC width
`define BLOCK_BYTES     8               // One memory block per Wishbone read
`define INST_PER_BLOCK  2               // Two instructions in a block

// ====================
// Fetch queue
// ====================
`define FIQ_NUM         4               // Entries, power of two
`define FIQ_IDX_WIDTH   2               // Entry index, pointers add a wrap bit

// ====================
// Dispatch
// ====================
`define DP_NUM          2               // Max instructions shown per cycle
`define DP_NUM_WIDTH    2               // Holds 0 to DP_NUM

// Boot address, must be block aligned
`define RESET_PC        32'h0000_1000

`endif
